//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int MEM_WORDS = 256;
	localparam int MEM_AW = 8;

	localparam logic [11:0] IMEM_BASE = 12'h000; // 1 KiB instruction memory.
	localparam logic [11:0] DMEM_BASE = 12'h400; // 1 KiB data memory.
	localparam logic [11:0] CTRL_ADDR = 12'h800;
	localparam logic [11:0] STATUS_ADDR = 12'h804;
	localparam logic [11:0] REG_BASE = 12'h880; // 32 read-only register words.

	localparam logic [4:0] ZERO_REG = 5'd0;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000; // sub and sra.

	typedef enum logic [6:0] {
		R_TYPE = 7'b0110011,
		I_ARITH_TYPE = 7'b0010011,
		I_LD_TYPE = 7'b0000011,
		S_TYPE = 7'b0100011,
		B_TYPE = 7'b1100011,
		I_JAL_TYPE = 7'b1100111, // jalr.
		J_TYPE = 7'b1101111,
		U_LD_TYPE = 7'b0110111, // lui.
		U_AUIPC_TYPE = 7'b0010111,
		I_BREAK_TYPE = 7'b1110011 // ecall and ebreak.
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_SUB = 5'd1,
		ALU_XOR = 5'd2,
		ALU_OR = 5'd3,
		ALU_AND = 5'd4,
		ALU_SLL = 5'd5,
		ALU_SRL = 5'd6,
		ALU_SRA = 5'd7,
		ALU_SLT = 5'd8,
		ALU_SLTU = 5'd9
	} alu_func_e;

	typedef enum logic [1:0] {
		BUS_NONE = 2'd0,
		BUS_LOAD = 2'd1,
		BUS_STORE = 2'd2
	} bus_cmd_e;

	typedef struct packed {
		logic vld;
		logic [31:0] pc;
		logic [31:0] inst;
	} if_id_t;

	typedef struct packed {
		logic vld;
		logic [31:0] alu_opa;
		logic [31:0] alu_opb;
		alu_func_e alu_func;
		bus_cmd_e mem_cmd;
		logic [31:0] mem_din;
		logic [4:0] rd;
		logic brk;
	} id_ex_t;

	typedef struct packed {
		logic we;
		logic [4:0] rd;
		logic [31:0] data;
	} wb_t;

endpackage

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input	logic							clk,
	input	logic							reset,
	input	logic							running,
	input	logic							start,
	input	logic							imem_we,
	input	logic	[rv_pkg::MEM_AW-1:0]	imem_addr,
	input	logic	[31:0]					imem_wdata,
	output	logic	[31:0]					imem_rdata,
	input	logic							flush,
	output	rv_pkg::if_id_t					if_id
);
	import rv_pkg::*;

	logic [31:0] imem [MEM_WORDS];
	logic [31:0] pc;

	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	assign imem_rdata = imem[imem_addr];

	always_ff @(posedge clk) begin
		if (reset || start)
			pc <= 32'h0000_0000; // start always runs from the first word.
		else if (running)
			pc <= pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if_id.pc <= pc;
		if_id.inst <= imem[pc[MEM_AW+1:2]];
		if (reset || flush)
			if_id.vld <= 1'b0; // a halt drops whatever was fetched behind it.
		else
			if_id.vld <= running;
	end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input	logic			clk,
	input	logic			reset,
	input	logic	[4:0]	rs1,
	input	logic	[4:0]	rs2,
	output	logic	[31:0]	rs1_data,
	output	logic	[31:0]	rs2_data,
	input	logic	[4:0]	host_idx,
	output	logic	[31:0]	host_data,
	input	rv_pkg::wb_t	wb
);
	import rv_pkg::*;

	logic [31:0] regs [32];

	// the write in execute lands at the same edge that closes decode.
	function automatic logic [31:0] read_port(input logic [4:0] idx);
		if (idx == ZERO_REG)
			return 32'h0000_0000;
		if (wb.we && wb.rd == idx)
			return wb.data;
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'h0000_0000;
		end else if (wb.we && wb.rd != ZERO_REG) begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
		host_data = (host_idx == ZERO_REG) ? 32'h0000_0000 : regs[host_idx];
	end

endmodule

`default_nettype wire

//--- logic/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input	logic			clk,
	input	logic			reset,
	input	rv_pkg::if_id_t	if_id,
	output	logic	[4:0]	rs1,
	output	logic	[4:0]	rs2,
	input	logic	[31:0]	rs1_data,
	input	logic	[31:0]	rs2_data,
	input	logic			flush,
	output	rv_pkg::id_ex_t	id_ex
);
	import rv_pkg::*;

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] imm_i, imm_s, imm_b, imm_u;
	id_ex_t dec;

	assign opcode = opcode_e'(if_id.inst[6:0]);
	assign funct3 = if_id.inst[14:12];
	assign funct7 = if_id.inst[31:25];
	assign rs1 = if_id.inst[19:15];
	assign rs2 = if_id.inst[24:20];

	assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
	assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
	assign imm_b = {{20{if_id.inst[31]}}, if_id.inst[7], if_id.inst[30:25],
		if_id.inst[11:8], 1'b0};
	assign imm_u = {if_id.inst[31:12], 12'h000};

	always_comb begin
		dec = '0;
		dec.vld = if_id.vld;
		dec.alu_func = ALU_ADD; // address, upper immediate and link all add.
		dec.rd = if_id.inst[11:7];
		dec.brk = (opcode == I_BREAK_TYPE);

		case (opcode)
			R_TYPE, I_ARITH_TYPE, I_LD_TYPE, S_TYPE:	dec.alu_opa = rs1_data;
			I_JAL_TYPE, B_TYPE, J_TYPE, U_AUIPC_TYPE:	dec.alu_opa = if_id.pc;
			default:									dec.alu_opa = 32'h0000_0000;
		endcase

		case (opcode)
			R_TYPE:							dec.alu_opb = rs2_data;
			I_ARITH_TYPE, I_LD_TYPE:		dec.alu_opb = imm_i;
			S_TYPE:							dec.alu_opb = imm_s;
			B_TYPE:							dec.alu_opb = imm_b;
			U_LD_TYPE, U_AUIPC_TYPE:		dec.alu_opb = imm_u;
			J_TYPE, I_JAL_TYPE:				dec.alu_opb = 32'h0000_0004;
			I_BREAK_TYPE:					dec.alu_opb = 32'h0000_0000;
			default:						dec.vld = 1'b0; // unknown opcode is dropped.
		endcase

		if (opcode == R_TYPE) begin
			case ({funct3, funct7})
				{F3_ADD_SUB, F7_BASE}:		dec.alu_func = ALU_ADD;
				{F3_ADD_SUB, F7_ALT}:		dec.alu_func = ALU_SUB;
				{F3_XOR, F7_BASE}:			dec.alu_func = ALU_XOR;
				{F3_OR, F7_BASE}:			dec.alu_func = ALU_OR;
				{F3_AND, F7_BASE}:			dec.alu_func = ALU_AND;
				{F3_SLL, F7_BASE}:			dec.alu_func = ALU_SLL;
				{F3_SRL_SRA, F7_BASE}:		dec.alu_func = ALU_SRL;
				{F3_SRL_SRA, F7_ALT}:		dec.alu_func = ALU_SRA;
				{F3_SLT, F7_BASE}:			dec.alu_func = ALU_SLT;
				{F3_SLTU, F7_BASE}:			dec.alu_func = ALU_SLTU;
				default:					dec.vld = 1'b0;
			endcase
		end

		if (opcode == I_ARITH_TYPE) begin
			case (funct3)
				F3_ADD_SUB:		dec.alu_func = ALU_ADD;
				F3_XOR:			dec.alu_func = ALU_XOR;
				F3_OR:			dec.alu_func = ALU_OR;
				F3_AND:			dec.alu_func = ALU_AND;
				F3_SLL:			dec.alu_func = ALU_SLL;
				F3_SRL_SRA:		dec.alu_func = if_id.inst[30] ? ALU_SRA : ALU_SRL;
				F3_SLT:			dec.alu_func = ALU_SLT;
				default:		dec.alu_func = ALU_SLTU;
			endcase
		end

		case (opcode)
			I_LD_TYPE:		dec.mem_cmd = BUS_LOAD;
			S_TYPE:			dec.mem_cmd = BUS_STORE;
			default:		dec.mem_cmd = BUS_NONE;
		endcase

		if (opcode == S_TYPE || opcode == B_TYPE || opcode == I_BREAK_TYPE)
			dec.rd = ZERO_REG;

		dec.mem_din = (dec.mem_cmd == BUS_STORE) ? rs2_data : 32'h0000_0000;
	end

	always_ff @(posedge clk) begin
		id_ex <= dec;
		if (reset || flush)
			id_ex.vld <= 1'b0;
	end

endmodule

`default_nettype wire

//--- logic/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input	logic							clk,
	input	logic							reset,
	input	rv_pkg::id_ex_t					id_ex,
	input	logic							dmem_we,
	input	logic	[rv_pkg::MEM_AW-1:0]	dmem_addr,
	input	logic	[31:0]					dmem_wdata,
	output	logic	[31:0]					dmem_rdata,
	output	rv_pkg::wb_t					wb,
	output	logic							halt
);
	import rv_pkg::*;

	logic [31:0] dmem [MEM_WORDS];
	logic [31:0] alu_res;
	logic [4:0] shamt;
	logic [MEM_AW-1:0] word_idx;
	logic is_store;
	logic is_load;
	logic ex_halt;

	assign shamt = id_ex.alu_opb[4:0];

	always_comb begin
		case (id_ex.alu_func)
			ALU_ADD:	alu_res = id_ex.alu_opa + id_ex.alu_opb;
			ALU_SUB:	alu_res = id_ex.alu_opa - id_ex.alu_opb;
			ALU_XOR:	alu_res = id_ex.alu_opa ^ id_ex.alu_opb;
			ALU_OR:		alu_res = id_ex.alu_opa | id_ex.alu_opb;
			ALU_AND:	alu_res = id_ex.alu_opa & id_ex.alu_opb;
			ALU_SLL:	alu_res = id_ex.alu_opa << shamt;
			ALU_SRL:	alu_res = id_ex.alu_opa >> shamt;
			ALU_SRA:	alu_res = $unsigned($signed(id_ex.alu_opa) >>> shamt);
			ALU_SLT:	alu_res = {31'b0, $signed(id_ex.alu_opa) < $signed(id_ex.alu_opb)};
			ALU_SLTU:	alu_res = {31'b0, id_ex.alu_opa < id_ex.alu_opb};
			default:	alu_res = 32'h0000_0000;
		endcase
	end

	// word accesses only, the low two address bits are ignored.
	assign word_idx = alu_res[MEM_AW+1:2];
	assign is_load = id_ex.vld && id_ex.mem_cmd == BUS_LOAD;
	assign is_store = id_ex.vld && id_ex.mem_cmd == BUS_STORE;
	assign ex_halt = id_ex.vld && id_ex.brk;

	always_ff @(posedge clk) begin
		if (dmem_we)
			dmem[dmem_addr] <= dmem_wdata; // host only writes while the core is stopped.
		else if (is_store)
			dmem[word_idx] <= id_ex.mem_din;
	end

	assign dmem_rdata = dmem[dmem_addr];

	always_comb begin
		wb.we = id_ex.vld && !id_ex.brk && id_ex.mem_cmd != BUS_STORE;
		wb.rd = id_ex.rd;
		wb.data = is_load ? dmem[word_idx] : alu_res;
	end

	assign halt = ex_halt;

endmodule

`default_nettype wire

//--- logic/apb_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_host_port (
	input	logic							clk,
	input	logic							reset,
	input	logic							psel,
	input	logic							penable,
	input	logic							pwrite,
	input	logic	[11:0]					paddr,
	input	logic	[31:0]					pwdata,
	output	logic	[31:0]					prdata,
	output	logic							pready,
	output	logic							pslverr,
	output	logic							imem_we,
	output	logic							dmem_we,
	output	logic	[rv_pkg::MEM_AW-1:0]	mem_addr,
	output	logic	[31:0]					mem_wdata,
	input	logic	[31:0]					imem_rdata,
	input	logic	[31:0]					dmem_rdata,
	output	logic	[4:0]					reg_idx,
	input	logic	[31:0]					reg_data,
	output	logic							start,
	output	logic							running,
	input	logic							halt
);
	import rv_pkg::*;

	logic access, halted, err;
	logic in_imem, in_dmem, is_ctrl, is_status, in_regs;

	assign access = psel && penable;
	assign in_imem = paddr[11:10] == IMEM_BASE[11:10];
	assign in_dmem = paddr[11:10] == DMEM_BASE[11:10];
	assign is_ctrl = paddr == CTRL_ADDR;
	assign is_status = paddr == STATUS_ADDR;
	assign in_regs = paddr[11:7] == REG_BASE[11:7];

	// memory writes and a start are refused while the core runs.
	always_comb begin
		err = !(in_imem || in_dmem || is_ctrl || is_status || in_regs);
		if (pwrite && running && (in_imem || in_dmem || (is_ctrl && pwdata[0])))
			err = 1'b1;
		if (pwrite && (is_status || in_regs))
			err = 1'b1;
	end

	assign pready = 1'b1;
	assign pslverr = access && err;
	assign mem_addr = paddr[MEM_AW+1:2];
	assign mem_wdata = pwdata;
	assign reg_idx = paddr[6:2];
	assign imem_we = access && pwrite && in_imem && !err;
	assign dmem_we = access && pwrite && in_dmem && !err;
	assign start = access && pwrite && is_ctrl && pwdata[0] && !err;

	always_comb begin
		if (in_imem)			prdata = imem_rdata;
		else if (in_dmem)		prdata = dmem_rdata;
		else if (is_ctrl)		prdata = {31'b0, running};
		else if (is_status)		prdata = {30'b0, halted, running};
		else if (in_regs)		prdata = reg_data;
		else					prdata = 32'h0000_0000;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			halted <= 1'b0;
		end else if (start) begin
			running <= 1'b1;
			halted <= 1'b0;
		end else if (halt) begin
			running <= 1'b0;
			halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
	input	logic			clk,
	input	logic			reset,
	input	logic			psel,
	input	logic			penable,
	input	logic			pwrite,
	input	logic	[11:0]	paddr,
	input	logic	[31:0]	pwdata,
	output	logic	[31:0]	prdata,
	output	logic			pready,
	output	logic			pslverr
);
	import rv_pkg::*;

	logic imem_we, dmem_we, start, running, halt;
	logic [MEM_AW-1:0] mem_addr;
	logic [31:0] mem_wdata, imem_rdata, dmem_rdata, reg_data;
	logic [4:0] reg_idx, rs1, rs2;
	logic [31:0] rs1_data, rs2_data;
	if_id_t if_id;
	id_ex_t id_ex;
	wb_t wb;

	apb_host_port u_host (
		.clk, .reset,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
		.imem_we, .dmem_we, .mem_addr, .mem_wdata, .imem_rdata, .dmem_rdata,
		.reg_idx, .reg_data, .start, .running, .halt
	);

	fetch_stage u_fetch (
		.clk, .reset, .running, .start,
		.imem_we, .imem_addr(mem_addr), .imem_wdata(mem_wdata), .imem_rdata,
		.flush(halt), .if_id
	);

	reg_file u_regs (
		.clk, .reset, .rs1, .rs2, .rs1_data, .rs2_data,
		.host_idx(reg_idx), .host_data(reg_data), .wb
	);

	id_stage u_id (
		.clk, .reset, .if_id, .rs1, .rs2, .rs1_data, .rs2_data,
		.flush(halt), .id_ex
	);

	ex_stage u_ex (
		.clk, .reset, .id_ex,
		.dmem_we, .dmem_addr(mem_addr), .dmem_wdata(mem_wdata), .dmem_rdata,
		.wb, .halt
	);

endmodule

`default_nettype wire

//--- dv/rv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions (
	input	logic				clk,
	input	logic				reset,
	input	logic				start,
	input	logic				running,
	input	logic				halted,
	input	logic				store_en,
	input	logic	[31:0]		x0_value,
	input	rv_pkg::opcode_e	dec_opcode,
	input	rv_pkg::wb_t		wb
);
	import rv_pkg::*;

	int fails = 0;

	run_or_halt: assert property (@(posedge clk) disable iff (reset) !(running && halted))
		else begin
			fails++;
			$error("running and halted are set together");
		end

	x0_stays_zero: assert property (@(posedge clk) disable iff (reset)
		(wb.we && wb.rd == ZERO_REG) |=> x0_value == 32'h0000_0000)
		else begin
			fails++;
			$error("a write to x0 changed its value");
		end

	// a store in execute was decoded from an S-type word one cycle earlier.
	store_only_for_store: assert property (@(posedge clk) disable iff (reset)
		store_en |-> $past(dec_opcode) == S_TYPE)
		else begin
			fails++;
			$error("data memory written by an instruction that is not a store");
		end

	run_needs_start: assert property (@(posedge clk) disable iff (reset)
		$rose(running) |-> $past(start))
		else begin
			fails++;
			$error("core began running without a start write");
		end

endmodule

bind rv_core_top rv_core_assertions u_assertions (
	.clk, .reset, .start, .running,
	.halted(u_host.halted), .store_en(u_ex.is_store), .x0_value(u_regs.regs[0]),
	.dec_opcode(u_id.opcode), .wb
);

`default_nettype wire

//--- dv/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
	import rv_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int MAX_CYCLES = 4000; // five programs of up to 40 words, polling and read-back.
	localparam int POLL_LIMIT = 100;
	// {alt, funct3} for add, sub, xor, or, and, sll, srl, sra, slt, sltu.
	localparam logic [3:0] ALU_SEQ [10] = '{4'h0, 4'h8, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5,
		4'hD, 4'h2, 4'h3};

	logic clk, reset, psel, penable, pwrite, pready, pslverr;
	logic [11:0] paddr;
	logic [31:0] pwdata, prdata;

	int cycle = 0;
	int errors = 0;
	logic [31:0] lfsr = 32'd54;
	logic [31:0] model_regs [32];
	logic [31:0] model_dmem [MEM_WORDS];
	logic [31:0] prog [$];

	rv_core_top dut (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	initial begin
		wait (cycle >= MAX_CYCLES);
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
		end
		return val;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, R_TYPE};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [6:0] opc);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, b);
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return sa >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// executes one instruction on the model and returns 1 when it halts.
	function automatic bit model_step(input logic [31:0] inst, input logic [31:0] pc);
		logic [31:0] a, b, imm_i, imm_s, addr, res;
		logic [2:0] f3;
		bit wr;
		a = model_regs[inst[19:15]];
		b = model_regs[inst[24:20]];
		f3 = inst[14:12];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		wr = 1'b1;
		res = '0;
		case (inst[6:0])
			R_TYPE: begin
				wr = inst[31:25] == 7'h00 ||
					(inst[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				res = ref_alu(f3, inst[30], a, b);
			end
			I_ARITH_TYPE: res = ref_alu(f3, f3 == 3'd5 && inst[30], a, imm_i);
			I_LD_TYPE: begin
				addr = a + imm_i;
				res = model_dmem[addr[9:2]];
			end
			S_TYPE: begin
				wr = 1'b0;
				addr = a + imm_s;
				model_dmem[addr[9:2]] = b;
			end
			U_LD_TYPE: res = {inst[31:12], 12'h000};
			U_AUIPC_TYPE: res = pc + {inst[31:12], 12'h000};
			J_TYPE, I_JAL_TYPE: res = pc + 32'd4; // link only, the pc never jumps.
			I_BREAK_TYPE: return 1'b1;
			default: wr = 1'b0; // branches and unknown opcodes.
		endcase
		if (wr && inst[11:7] != ZERO_REG)
			model_regs[inst[11:7]] = res;
		return 1'b0;
	endfunction

	task automatic model_run();
		for (int i = 0; i < prog.size(); i++)
			if (model_step(prog[i], 32'(i * 4)))
				break;
	endtask

	task automatic apb_access(input logic write, input logic [11:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		rdata = prdata;
		err = pslverr;
		check_word("pready", 32'h1, 32'(pready));
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, got);
		assert (got === exp)
		else begin
			errors++;
			$display("ERR %s exp %h got %h", name, exp, got);
		end
	endtask

	task automatic write_expect(input logic [11:0] addr, input logic [31:0] data,
		input logic exp_err);
		logic [31:0] rdata;
		logic err;
		apb_access(1'b1, addr, data, rdata, err);
		check_word($sformatf("pslverr@%h", addr), 32'(exp_err), 32'(err));
	endtask

	task automatic read_expect(input string name, input logic [11:0] addr,
		input logic [31:0] exp, input logic exp_err);
		logic [31:0] rdata;
		logic err;
		apb_access(1'b0, addr, '0, rdata, err);
		check_word($sformatf("pslverr@%h", addr), 32'(exp_err), 32'(err));
		check_word(name, exp, rdata);
	endtask

	task automatic wait_halt();
		logic [31:0] status;
		logic err;
		int first;
		first = cycle;
		status = '0;
		while (!status[1] && cycle - first < POLL_LIMIT)
			apb_access(1'b0, STATUS_ADDR, '0, status, err);
		assert (status[1])
		else begin
			errors++;
			$display("core did not halt within %0d cycles of polling", POLL_LIMIT);
		end
		check_word("status", 32'h0000_0002, status);
	endtask

	task automatic check_regs();
		for (int r = 0; r < 32; r++)
			read_expect($sformatf("x%0d", r), REG_BASE + 12'(r * 4), model_regs[r], 1'b0);
	endtask

	task automatic run_program();
		for (int i = 0; i < prog.size(); i++)
			write_expect(IMEM_BASE + 12'(i * 4), prog[i], 1'b0);
		write_expect(CTRL_ADDR, 32'h1, 1'b0);
		model_run();
		wait_halt();
		check_regs();
	endtask

	// a chain where each result feeds the next, alternating R-type and I-type.
	task automatic build_arith_program();
		logic [3:0] op;
		logic [11:0] imm;
		logic [4:0] rd;
		prog = {};
		prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'd0, 5'd1, I_ARITH_TYPE));
		rd = 5'd2;
		for (int k = 0; k < 10; k++) begin
			op = ALU_SEQ[k];
			prog.push_back(enc_r({1'b0, op[3], 5'b0}, rd - 5'd2, rd - 5'd1, op[2:0], rd));
			rd++;
			if (k != 1) begin // there is no subi.
				if (op[1:0] == 2'b01)
					imm = {1'b0, op[3], 5'b0, 5'(rand_bits(5))};
				else
					imm = 12'(rand_bits(12));
				prog.push_back(enc_i(imm, rd - 5'd1, op[2:0], rd, I_ARITH_TYPE));
				rd++;
			end
		end
		prog.push_back(32'h0010_0073);
	endtask

	initial begin
		logic [31:0] st_addr;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		reset = 1'b1;
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		read_expect("status", STATUS_ADDR, 32'h0, 1'b0);
		for (int i = 0; i < 4; i++) begin
			model_dmem[i] = rand_bits(32);
			write_expect(DMEM_BASE + 12'(i * 4), model_dmem[i], 1'b0);
		end
		for (int i = 0; i < 4; i++)
			read_expect($sformatf("dmem[%0d]", i), DMEM_BASE + 12'(i * 4), model_dmem[i], 1'b0);
		read_expect("unmapped", 12'hC00, 32'h0, 1'b1);

		build_arith_program();
		for (int i = 0; i < prog.size(); i++)
			write_expect(IMEM_BASE + 12'(i * 4), prog[i], 1'b0);
		write_expect(CTRL_ADDR, 32'h1, 1'b0);
		write_expect(DMEM_BASE, ~model_dmem[0], 1'b1); // refused while running.
		write_expect(IMEM_BASE + 12'((prog.size() - 2) * 4), 32'h0010_0073, 1'b1);
		write_expect(CTRL_ADDR, 32'h1, 1'b1);
		read_expect("status", STATUS_ADDR, 32'h1, 1'b0);
		model_run();
		wait_halt();
		check_regs();
		read_expect("dmem[0]", DMEM_BASE, model_dmem[0], 1'b0);

		prog = {};
		prog.push_back(enc_u(20'(rand_bits(20)), 5'd21, U_LD_TYPE));
		prog.push_back(enc_u(20'(rand_bits(20)), 5'd22, U_AUIPC_TYPE));
		prog.push_back(enc_s(12'(rand_bits(12)), 5'd22, 5'd21, 3'd0, B_TYPE));
		prog.push_back(enc_u(20'(rand_bits(20)), 5'd23, J_TYPE));
		prog.push_back(enc_i(12'(rand_bits(12)), 5'd21, 3'd0, 5'd24, I_JAL_TYPE));
		prog.push_back(enc_s(12'(rand_bits(12)), 5'd24, 5'd23, 3'd1, B_TYPE));
		prog.push_back(enc_i(12'h001, 5'd23, 3'd0, 5'd25, I_ARITH_TYPE));
		prog.push_back(32'h0000_0073); // ecall halts as well.
		run_program();

		prog = {};
		prog.push_back(enc_i({2'b00, 8'(rand_bits(8)), 2'b00}, 5'd0, 3'd0, 5'd26, I_ARITH_TYPE));
		prog.push_back(enc_r(7'h00, 5'd22, 5'd21, 3'd0, 5'd27));
		prog.push_back(enc_s(12'd8, 5'd27, 5'd26, 3'b010, S_TYPE));
		prog.push_back(enc_i(12'd8, 5'd26, 3'b010, 5'd28, I_LD_TYPE));
		prog.push_back(enc_i(12'd1, 5'd28, 3'd0, 5'd29, I_ARITH_TYPE));
		prog.push_back(enc_i(12'd4, 5'd0, 3'b010, 5'd30, I_LD_TYPE));
		prog.push_back(32'h0010_0073);
		run_program();
		st_addr = model_regs[26] + 32'd8;
		read_expect("dmem store", DMEM_BASE + {2'b00, st_addr[9:2], 2'b00},
			model_dmem[st_addr[9:2]], 1'b0);

		prog = {};
		prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'd0, 5'd0, I_ARITH_TYPE));
		prog.push_back(enc_r(7'h00, 5'd20, 5'd19, 3'd0, 5'd0));
		prog.push_back({25'(rand_bits(25)), 7'h7F});
		prog.push_back(enc_r(7'h01, 5'd20, 5'd19, 3'd0, 5'd31));
		prog.push_back(enc_i(12'd1, 5'd30, 3'd0, 5'd30, I_ARITH_TYPE));
		prog.push_back(32'h0010_0073);
		prog.push_back(enc_i(12'h7FF, 5'd0, 3'd0, 5'd31, I_ARITH_TYPE));
		prog.push_back(enc_i(12'h123, 5'd0, 3'd0, 5'd29, I_ARITH_TYPE));
		run_program();
		write_expect(CTRL_ADDR, 32'h1, 1'b0); // same program again from pc 0.
		model_run();
		wait_halt();
		check_regs();

		$display("checks failed: %0d in testbench, %0d in assertions", errors,
			dut.u_assertions.fails);
		if (errors == 0 && dut.u_assertions.fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/apb_host_port.sv
logic/rv_core_top.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - logic/rv_pkg.sv
      - logic/fetch_stage.sv
      - logic/reg_file.sv
      - logic/id_stage.sv
      - logic/ex_stage.sv
      - logic/apb_host_port.sv
      - logic/rv_core_top.sv
  - target: test
    files:
      - dv/rv_core_assertions.sv
      - dv/rv_core_tb.sv
